// File: verilog/tmr_cfg.svh
//----------------------------------------------------------
// timer bank build parameters, one value per build
// TMR_NUM_CH must stay within 1..(1 << TMR_CH_W)
// address is a byte address, bits [1:0] are ignored
//----------------------------------------------------------
`ifndef TMR_CFG_SVH
`define TMR_CFG_SVH

// number of populated timer channels
`define TMR_NUM_CH 4

// channel index field, top bits of the address
// 16 slots, slots at or above TMR_NUM_CH answer with err
`define TMR_CH_W 4

// address bits decoded by the slave
// [7:4] channel, [3:2] register, [1:0] byte lane
`define TMR_ADDR_W 8

`endif

// File: verilog/tmr_pkg.sv
//----------------------------------------------------------
// shared types for the timer bank
// control bits above CTRL_RELOAD do not exist and read zero
//----------------------------------------------------------
package tmr_pkg;

    // register offset, word index inside a channel
    // offset 3 has no register behind it
    typedef enum logic [1:0] {
        REG_CTRL  = 2'd0,
        REG_COUNT = 2'd1,
        REG_VALUE = 2'd2
    } reg_off_e;

    // bus front end states
    typedef enum logic {
        // waiting for a new classic cycle
        DEC_IDLE = 1'b0,
        // ack or err on the bus
        DEC_RESP = 1'b1
    } dec_state_e;

    // control register bit positions
    // timer runs while set
    localparam int unsigned CTRL_EN     = 0;
    // lets pending reach the interrupt line
    localparam int unsigned CTRL_IE     = 1;
    // expiry flag, write 1 to clear
    localparam int unsigned CTRL_PEND   = 2;
    // keep running after expiry
    localparam int unsigned CTRL_RELOAD = 3;

endpackage

// File: verilog/tmr_bus_if.sv
//----------------------------------------------------------
// per-channel register bus, one instance per timer
// acc is a single-cycle strobe, rdata is zero outside ack
//----------------------------------------------------------
interface tmr_bus_if;

    // one-cycle access strobe for this channel
    logic                 acc;
    // 1 = write, 0 = read
    logic                 we;
    // register inside the channel
    tmr_pkg::reg_off_e    off;
    // write data, full word only
    logic [31:0]          wdata;
    // registered read data, zero unless read last cycle
    logic [31:0]          rdata;
    // pending and interrupt enable
    logic                 irq;

    // bus front end drives the request side
    modport dec (
        output acc,
        output we,
        output off,
        output wdata
    );

    // timer consumes requests, returns data and irq
    modport ch (
        input  acc,
        input  we,
        input  off,
        input  wdata,
        output rdata,
        output irq
    );

    // response side only
    modport col (
        input  rdata,
        input  irq
    );

endinterface

// File: verilog/wb_tmr_decoder.sv
//----------------------------------------------------------
// Wishbone classic slave front end, no wb_sel, no pipelining
// master must hold cyc/stb/we/adr/dat until ack or err
// and drop stb for a cycle before the next access
//----------------------------------------------------------
`include "tmr_cfg.svh"

module wb_tmr_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [`TMR_ADDR_W-1:0] wb_adr_i,
    input  logic [31:0]            wb_dat_i,
    output logic                   wb_ack_o,
    output logic                   wb_err_o,
    tmr_bus_if.dec                 ch_o [`TMR_NUM_CH]
);

    // lowest bit of the channel index field
    localparam int CH_LSB  = `TMR_ADDR_W - `TMR_CH_W;
    // lowest bit of the register offset field
    localparam int OFF_LSB = CH_LSB - $bits(tmr_pkg::reg_off_e);

    tmr_pkg::dec_state_e    state_q;
    logic                   ack_q;
    logic                   err_q;
    logic                   req;
    logic                   ch_hit;
    logic [`TMR_CH_W-1:0]   ch_idx;
    tmr_pkg::reg_off_e      off;

    // address split
    assign ch_idx = wb_adr_i[`TMR_ADDR_W-1:CH_LSB];
    // offset 3 passes through, channel reads it as zero
    assign off    = tmr_pkg::reg_off_e'(wb_adr_i[CH_LSB-1:OFF_LSB]);

    // index falls on a populated slot
    assign ch_hit = (32'(ch_idx) < `TMR_NUM_CH);

    // new cycle seen, only once per classic cycle
    // stb is ignored while the response is out
    assign req = wb_cyc_i && wb_stb_i && (state_q == tmr_pkg::DEC_IDLE);

    // strobe fans out to the addressed channel only
    for (genvar i = 0; i < `TMR_NUM_CH; i++) begin : g_ch
        assign ch_o[i].acc   = req && (ch_idx == `TMR_CH_W'(i));
        assign ch_o[i].we    = wb_we_i;
        assign ch_o[i].off   = off;
        assign ch_o[i].wdata = wb_dat_i;
    end

    // response FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= tmr_pkg::DEC_IDLE;
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                tmr_pkg::DEC_IDLE: begin
                    // answer lands one cycle after the request
                    ack_q <= req && ch_hit;
                    err_q <= req && !ch_hit;
                    if (req) begin
                        state_q <= tmr_pkg::DEC_RESP;
                    end
                end
                tmr_pkg::DEC_RESP: begin
                    // single-cycle response, then back to idle
                    ack_q   <= 1'b0;
                    err_q   <= 1'b0;
                    state_q <= tmr_pkg::DEC_IDLE;
                end
                default: begin
                    ack_q   <= 1'b0;
                    err_q   <= 1'b0;
                    state_q <= tmr_pkg::DEC_IDLE;
                end
            endcase
        end
    end

    assign wb_ack_o = ack_q;
    assign wb_err_o = err_q;

endmodule

// File: verilog/tmr_channel.sv
//----------------------------------------------------------
// one 32-bit count-up timer, no prescaler
// expiry when enabled and count >= value, checked every cycle
// W1C of pending loses against an expiry in the same cycle
//----------------------------------------------------------
module tmr_channel (
    input  logic   clk,
    input  logic   rst_n,
    tmr_bus_if.ch  bus_i
);

    // only the four defined control bits are stored
    logic [tmr_pkg::CTRL_RELOAD:0] ctrl_q;
    logic [31:0]                   count_q;
    logic [31:0]                   value_q;
    logic [31:0]                   rdata_q;

    logic                          wr;
    logic                          rd;
    logic                          ctrl_wr;
    logic                          value_wr;
    logic                          expire;
    logic                          pend_clr;

    // access decode
    assign wr       = bus_i.acc && bus_i.we;
    assign rd       = bus_i.acc && !bus_i.we;
    assign ctrl_wr  = wr && (bus_i.off == tmr_pkg::REG_CTRL);
    assign value_wr = wr && (bus_i.off == tmr_pkg::REG_VALUE);

    // expiry seen on every cycle, writes included
    assign expire   = ctrl_q[tmr_pkg::CTRL_EN] && (count_q >= value_q);

    // write 1 to clear of the pending bit
    assign pend_clr = ctrl_wr && bus_i.wdata[tmr_pkg::CTRL_PEND];

    // counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= 32'd0;
        end else if (expire) begin
            // wrap back to zero on expiry
            count_q <= 32'd0;
        end else if (ctrl_q[tmr_pkg::CTRL_EN]) begin
            count_q <= count_q + 32'd1;
        end else begin
            // parked at zero while disabled
            count_q <= 32'd0;
        end
    end

    // control register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else begin
            // pending merges clear and expiry, expiry wins
            ctrl_q[tmr_pkg::CTRL_PEND] <= (ctrl_q[tmr_pkg::CTRL_PEND] && !pend_clr) || expire;
            if (ctrl_wr) begin
                // software bits take the written value
                ctrl_q[tmr_pkg::CTRL_EN]     <= bus_i.wdata[tmr_pkg::CTRL_EN];
                ctrl_q[tmr_pkg::CTRL_IE]     <= bus_i.wdata[tmr_pkg::CTRL_IE];
                ctrl_q[tmr_pkg::CTRL_RELOAD] <= bus_i.wdata[tmr_pkg::CTRL_RELOAD];
            end else if (expire && !ctrl_q[tmr_pkg::CTRL_RELOAD]) begin
                // one-shot stops itself
                ctrl_q[tmr_pkg::CTRL_EN] <= 1'b0;
            end
        end
    end

    // compare value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value_q <= 32'd0;
        end else if (value_wr) begin
            value_q <= bus_i.wdata;
        end
    end

    // read data, captured on the access edge
    // back to zero on the next cycle so the collector can OR
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_q <= 32'd0;
        end else if (rd) begin
            case (bus_i.off)
                tmr_pkg::REG_CTRL: begin
                    // upper bits read zero
                    rdata_q <= 32'(ctrl_q);
                end
                tmr_pkg::REG_COUNT: begin
                    rdata_q <= count_q;
                end
                tmr_pkg::REG_VALUE: begin
                    rdata_q <= value_q;
                end
                default: begin
                    // unmapped offset
                    rdata_q <= 32'd0;
                end
            endcase
        end else begin
            rdata_q <= 32'd0;
        end
    end

    assign bus_i.rdata = rdata_q;

    // level interrupt, pending gated by enable
    assign bus_i.irq = ctrl_q[tmr_pkg::CTRL_PEND] && ctrl_q[tmr_pkg::CTRL_IE];

endmodule

// File: verilog/tmr_rsp_collect.sv
//----------------------------------------------------------
// merges channel responses onto the bus
// read data is a plain OR, only the accessed channel is non-zero
// irq_vec_o lags the channel irq by one cycle
//----------------------------------------------------------
`include "tmr_cfg.svh"

module tmr_rsp_collect (
    input  logic                   clk,
    input  logic                   rst_n,
    tmr_bus_if.col                 ch_i [`TMR_NUM_CH],
    output logic [31:0]            wb_dat_o,
    output logic [`TMR_NUM_CH-1:0] irq_vec_o,
    output logic                   irq_o
);

    logic [31:0]            rdata_arr [`TMR_NUM_CH];
    logic [`TMR_NUM_CH-1:0] irq_raw;
    logic [`TMR_NUM_CH-1:0] irq_vec_q;
    logic [31:0]            rdata_or;

    // interface array needs constant indices
    for (genvar i = 0; i < `TMR_NUM_CH; i++) begin : g_ch
        assign rdata_arr[i] = ch_i[i].rdata;
        assign irq_raw[i]   = ch_i[i].irq;
    end

    // read data merge
    always_comb begin
        rdata_or = 32'd0;
        for (int i = 0; i < `TMR_NUM_CH; i++) begin
            rdata_or = rdata_or | rdata_arr[i];
        end
    end

    // combinational, valid in the ack cycle
    assign wb_dat_o = rdata_or;

    // pending vector
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_vec_q <= '0;
        end else begin
            irq_vec_q <= irq_raw;
        end
    end

    assign irq_vec_o = irq_vec_q;

    // single line, any channel
    assign irq_o = |irq_vec_q;

endmodule

// File: verilog/tmr_subsys.sv
//----------------------------------------------------------
// timer bank top, Wishbone classic slave, 32-bit words only
// one-cycle ack or err, no wait states, no back-pressure
// slots above the populated channels answer with err
//----------------------------------------------------------
`include "tmr_cfg.svh"

module tmr_subsys (
    input  logic                   clk,
    input  logic                   rst_n,

    // Wishbone classic slave
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [`TMR_ADDR_W-1:0] wb_adr_i,
    input  logic [31:0]            wb_dat_i,
    output logic [31:0]            wb_dat_o,
    output logic                   wb_ack_o,
    output logic                   wb_err_o,

    // interrupts
    output logic                   irq_o,
    output logic [`TMR_NUM_CH-1:0] irq_vec_o
);

    // one register bus per channel
    tmr_bus_if ch_bus [`TMR_NUM_CH] ();

    // bus front end
    wb_tmr_decoder u_dec (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_ack_o (wb_ack_o),
        .wb_err_o (wb_err_o),
        .ch_o     (ch_bus)
    );

    // timer channels
    for (genvar i = 0; i < `TMR_NUM_CH; i++) begin : g_ch
        tmr_channel u_ch (
            .clk   (clk),
            .rst_n (rst_n),
            .bus_i (ch_bus[i])
        );
    end

    // read data and interrupt merge
    tmr_rsp_collect u_col (
        .clk       (clk),
        .rst_n     (rst_n),
        .ch_i      (ch_bus),
        .wb_dat_o  (wb_dat_o),
        .irq_vec_o (irq_vec_o),
        .irq_o     (irq_o)
    );

endmodule

// File: tests/tmr_checker.sv
//----------------------------------------------------------
// response checker for the timer bank testbench
// a response is due in the cycle after a new request
// expectations must be set at least one cycle before ack
//----------------------------------------------------------
`include "tmr_cfg.svh"

module tmr_checker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cyc_i,
    input  logic                   stb_i,
    input  logic                   ack_i,
    input  logic                   err_i,
    input  logic [31:0]            dat_i,
    input  logic [`TMR_NUM_CH-1:0] irq_vec_i,
    input  logic                   irq_i,
    input  int                     exp_id_i,
    input  logic [31:0]            exp_dat_i,
    input  logic                   exp_err_i,
    input  logic [`TMR_NUM_CH-1:0] exp_vec_i,
    output int                     pass_cnt_o,
    output int                     fail_cnt_o
);

    timeunit 1ns;
    timeprecision 1ps;

    logic req_d;
    // first cycle of a request, seen at the last posedge
    logic req_first;

    always @(posedge clk) begin
        if (!rst_n) begin
            req_d     <= 1'b0;
            req_first <= 1'b0;
        end else begin
            req_d     <= cyc_i && stb_i;
            req_first <= cyc_i && stb_i && !req_d;
        end
    end

    // outputs are flop driven, stable at the falling edge
    always @(negedge clk) begin
        int errs;
        errs = 0;
        if (!rst_n) begin
            pass_cnt_o = 0;
            fail_cnt_o = 0;
        end else if (req_first) begin
            if (!ack_i && !err_i) begin
                $display("test %0d: no ack and no err in the cycle after the request",
                         exp_id_i);
                errs++;
            end else begin
                if (err_i !== exp_err_i) begin
                    $display("** Error wb_err_o test %0d: expected %h, got %h",
                             exp_id_i, exp_err_i, err_i);
                    errs++;
                end
                if (ack_i !== !exp_err_i) begin
                    $display("** Error wb_ack_o test %0d: expected %h, got %h",
                             exp_id_i, !exp_err_i, ack_i);
                    errs++;
                end
                // writes and errors return zero data too
                if (dat_i !== exp_dat_i) begin
                    $display("** Error wb_dat_o test %0d: expected %h, got %h",
                             exp_id_i, exp_dat_i, dat_i);
                    errs++;
                end
                if (irq_vec_i !== exp_vec_i) begin
                    $display("** Error irq_vec_o test %0d: expected %h, got %h",
                             exp_id_i, exp_vec_i, irq_vec_i);
                    errs++;
                end
                if (irq_i !== |exp_vec_i) begin
                    $display("** Error irq_o test %0d: expected %h, got %h",
                             exp_id_i, |exp_vec_i, irq_i);
                    errs++;
                end
            end
            if (errs == 0) begin
                pass_cnt_o++;
                $display("test %0d: ok", exp_id_i);
            end else begin
                fail_cnt_o++;
                $display("test %0d: FAILED", exp_id_i);
            end
        end else if (ack_i || err_i) begin
            // stray response, no new request behind it
            $display("response seen without a new request, last test %0d", exp_id_i);
            fail_cnt_o++;
        end
    end

endmodule

// File: tests/tb_tmr_subsys.sv
//----------------------------------------------------------
// testbench for the timer bank with TMR_NUM_CH = 4
// one classic cycle per table entry
// inputs change on the falling edge
// expected values follow the counter and control write rules
//----------------------------------------------------------
`include "tmr_cfg.svh"

module tb_tmr_subsys;

    timeunit 1ns;
    timeprecision 1ps;

    // control register bits as software sees them
    localparam logic [31:0] C_EN     = 32'd1 << tmr_pkg::CTRL_EN;
    localparam logic [31:0] C_IE     = 32'd1 << tmr_pkg::CTRL_IE;
    localparam logic [31:0] C_PEND   = 32'd1 << tmr_pkg::CTRL_PEND;
    localparam logic [31:0] C_RELOAD = 32'd1 << tmr_pkg::CTRL_RELOAD;
    localparam logic [`TMR_NUM_CH-1:0] NO_IRQ = '0;
    // negedges to wait for ack or err before giving up
    localparam int RESP_LIMIT = 4;

    // one bus access and what should come back
    typedef struct {
        int                     id;
        logic                   we;
        int                     ch;
        logic [1:0]             off;
        logic [31:0]            wdata;
        int                     idle;
        logic [31:0]            exp_dat;
        logic                   exp_err;
        logic [`TMR_NUM_CH-1:0] exp_vec;
    } test_t;

    logic                   clk;
    logic                   rst_n;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`TMR_ADDR_W-1:0] wb_adr;
    logic [31:0]            wb_wdat;
    logic [31:0]            wb_rdat;
    logic                   wb_ack;
    logic                   wb_err;
    logic                   irq;
    logic [`TMR_NUM_CH-1:0] irq_vec;

    // expectations handed to the checker
    int                     exp_id;
    logic [31:0]            exp_dat;
    logic                   exp_err;
    logic [`TMR_NUM_CH-1:0] exp_vec;
    int                     pass_cnt;
    int                     fail_cnt;

    test_t                  tests [$];
    logic [31:0]            rnd_val [`TMR_NUM_CH];
    int                     cycle_cnt = 0;
    int                     timeout_lim = 0;

    tmr_subsys uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_cyc_i  (wb_cyc),
        .wb_stb_i  (wb_stb),
        .wb_we_i   (wb_we),
        .wb_adr_i  (wb_adr),
        .wb_dat_i  (wb_wdat),
        .wb_dat_o  (wb_rdat),
        .wb_ack_o  (wb_ack),
        .wb_err_o  (wb_err),
        .irq_o     (irq),
        .irq_vec_o (irq_vec)
    );

    tmr_checker u_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .cyc_i      (wb_cyc),
        .stb_i      (wb_stb),
        .ack_i      (wb_ack),
        .err_i      (wb_err),
        .dat_i      (wb_rdat),
        .irq_vec_i  (irq_vec),
        .irq_i      (irq),
        .exp_id_i   (exp_id),
        .exp_dat_i  (exp_dat),
        .exp_err_i  (exp_err),
        .exp_vec_i  (exp_vec),
        .pass_cnt_o (pass_cnt),
        .fail_cnt_o (fail_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run length guard
    // limit is set once the table is built
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_lim > 0 && cycle_cnt >= timeout_lim) begin
            $display("timeout: run still busy after %0d cycles", timeout_lim);
            $display("Simulation failed");
            $finish;
        end
    end

    // 32-bit LCG with the numerical recipes constants
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // byte address with the lane bits at zero
    function automatic logic [`TMR_ADDR_W-1:0] make_addr(input int ch, input logic [1:0] off);
        logic [`TMR_ADDR_W-1:0] a;
        a = '0;
        a[`TMR_ADDR_W-1 -: `TMR_CH_W] = ch[`TMR_CH_W-1:0];
        a[`TMR_ADDR_W-`TMR_CH_W-1 -: 2] = off;
        return a;
    endfunction

    // one-hot pending vector for a channel
    function automatic logic [`TMR_NUM_CH-1:0] ch_bit(input int c);
        logic [`TMR_NUM_CH-1:0] v;
        v = '0;
        v[c] = 1'b1;
        return v;
    endfunction

    task automatic add_entry(input logic we, input int ch, input logic [1:0] off,
                             input logic [31:0] wdata, input int idle,
                             input logic [31:0] exp_d, input logic exp_e,
                             input logic [`TMR_NUM_CH-1:0] exp_v);
        test_t e;
        e.id      = tests.size() + 1;
        e.we      = we;
        e.ch      = ch;
        e.off     = off;
        e.wdata   = wdata;
        e.idle    = idle;
        e.exp_dat = exp_d;
        e.exp_err = exp_e;
        e.exp_vec = exp_v;
        tests.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] seed;
        seed = 32'hd3f4;
        for (int c = 0; c < `TMR_NUM_CH; c++) begin
            seed = lcg_next(seed);
            rnd_val[c] = seed;
        end
        // read back of value and ctrl
        // upper ctrl bits dropped and count parked at 0
        add_entry(1, 0, tmr_pkg::REG_VALUE, 32'd10, 0, 32'd0, 0, NO_IRQ);
        add_entry(0, 0, tmr_pkg::REG_VALUE, 32'd0, 0, 32'd10, 0, NO_IRQ);
        add_entry(1, 0, tmr_pkg::REG_CTRL, 32'hffff_fff8, 0, 32'd0, 0, NO_IRQ);
        add_entry(0, 0, tmr_pkg::REG_CTRL, 32'd0, 0, C_RELOAD, 0, NO_IRQ);
        add_entry(1, 0, tmr_pkg::REG_CTRL, 32'd0, 0, 32'd0, 0, NO_IRQ);
        add_entry(0, 0, tmr_pkg::REG_COUNT, 32'd0, 0, 32'd0, 0, NO_IRQ);
        // one-shot with value 10 read well after expiry
        add_entry(1, 0, tmr_pkg::REG_CTRL, C_EN | C_IE, 0, 32'd0, 0, NO_IRQ);
        add_entry(0, 0, tmr_pkg::REG_CTRL, 32'd0, 16, C_PEND | C_IE, 0, ch_bit(0));
        add_entry(0, 0, tmr_pkg::REG_COUNT, 32'd0, 0, 32'd0, 0, ch_bit(0));
        // W1C with the vector still old in the ack cycle
        add_entry(1, 0, tmr_pkg::REG_CTRL, C_IE | C_PEND, 0, 32'd0, 0, ch_bit(0));
        add_entry(0, 0, tmr_pkg::REG_CTRL, 32'd0, 0, C_IE, 0, NO_IRQ);
        // masked expiry on ch2
        add_entry(1, 2, tmr_pkg::REG_VALUE, 32'd3, 0, 32'd0, 0, NO_IRQ);
        add_entry(1, 2, tmr_pkg::REG_CTRL, C_EN, 0, 32'd0, 0, NO_IRQ);
        add_entry(0, 2, tmr_pkg::REG_CTRL, 32'd0, 10, C_PEND, 0, NO_IRQ);
        // auto-reload on ch1 then stop and clear
        add_entry(1, 1, tmr_pkg::REG_VALUE, 32'd5, 0, 32'd0, 0, NO_IRQ);
        add_entry(1, 1, tmr_pkg::REG_CTRL, C_EN | C_IE | C_RELOAD, 0, 32'd0, 0, NO_IRQ);
        add_entry(0, 1, tmr_pkg::REG_CTRL, 32'd0, 12, 32'hf, 0, ch_bit(1));
        add_entry(1, 1, tmr_pkg::REG_CTRL, C_IE, 0, 32'd0, 0, ch_bit(1));
        // stopped mid-count so the count parks at zero
        add_entry(0, 1, tmr_pkg::REG_COUNT, 32'd0, 0, 32'd0, 0, ch_bit(1));
        add_entry(1, 1, tmr_pkg::REG_CTRL, C_PEND, 0, 32'd0, 0, ch_bit(1));
        add_entry(0, 1, tmr_pkg::REG_CTRL, 32'd0, 0, 32'd0, 0, NO_IRQ);
        // ch3 W1C lands on the expiry edge (enable + value + 1)
        add_entry(1, 3, tmr_pkg::REG_VALUE, 32'd4, 0, 32'd0, 0, NO_IRQ);
        add_entry(1, 3, tmr_pkg::REG_CTRL, C_EN, 0, 32'd0, 0, NO_IRQ);
        add_entry(1, 3, tmr_pkg::REG_CTRL, C_PEND, 3, 32'd0, 0, NO_IRQ);
        add_entry(0, 3, tmr_pkg::REG_CTRL, 32'd0, 0, C_PEND, 0, NO_IRQ);
        add_entry(1, 3, tmr_pkg::REG_CTRL, C_PEND, 0, 32'd0, 0, NO_IRQ);
        // empty slots and the unmapped offset
        add_entry(0, `TMR_NUM_CH, tmr_pkg::REG_CTRL, 32'd0, 0, 32'd0, 1, NO_IRQ);
        add_entry(1, 15, tmr_pkg::REG_VALUE, 32'h1234, 0, 32'd0, 1, NO_IRQ);
        add_entry(0, 0, 2'd3, 32'd0, 0, 32'd0, 0, NO_IRQ);
        // every channel keeps its own value and ctrl
        for (int c = 0; c < `TMR_NUM_CH; c++) begin
            add_entry(1, c, tmr_pkg::REG_VALUE, rnd_val[c], 0, 32'd0, 0, NO_IRQ);
        end
        for (int c = 0; c < `TMR_NUM_CH; c++) begin
            add_entry(0, c, tmr_pkg::REG_VALUE, 32'd0, 0, rnd_val[c], 0, NO_IRQ);
        end
        add_entry(0, 0, tmr_pkg::REG_CTRL, 32'd0, 0, C_IE, 0, NO_IRQ);
        add_entry(0, 1, tmr_pkg::REG_CTRL, 32'd0, 0, 32'd0, 0, NO_IRQ);
        add_entry(0, 2, tmr_pkg::REG_CTRL, 32'd0, 0, C_PEND, 0, NO_IRQ);
        add_entry(0, 3, tmr_pkg::REG_CTRL, 32'd0, 0, 32'd0, 0, NO_IRQ);
    endtask

    // one classic cycle with stb dropped in the response cycle
    task automatic run_test(input test_t t);
        int waited;
        repeat (t.idle) @(negedge clk);
        @(negedge clk);
        exp_id  = t.id;
        exp_dat = t.exp_dat;
        exp_err = t.exp_err;
        exp_vec = t.exp_vec;
        wb_adr  = make_addr(t.ch, t.off);
        wb_wdat = t.wdata;
        wb_we   = t.we;
        wb_cyc  = 1'b1;
        wb_stb  = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!(wb_ack || wb_err) && waited < RESP_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    initial begin
        rst_n   = 1'b0;
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        wb_adr  = '0;
        wb_wdat = 32'd0;
        exp_id  = 0;
        exp_dat = 32'd0;
        exp_err = 1'b0;
        exp_vec = '0;
        build_table();
        timeout_lim = 100;
        foreach (tests[i]) begin
            timeout_lim += tests[i].idle + 4;
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        foreach (tests[i]) begin
            run_test(tests[i]);
        end
        // let the checker settle its last count
        repeat (2) @(posedge clk);
        $display("tests %0d, passed %0d, failed %0d", tests.size(), pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == tests.size()) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+verilog
verilog/tmr_pkg.sv
verilog/tmr_bus_if.sv
verilog/wb_tmr_decoder.sv
verilog/tmr_channel.sv
verilog/tmr_rsp_collect.sv
verilog/tmr_subsys.sv
tests/tmr_checker.sv
tests/tb_tmr_subsys.sv

// File: run.sh
#!/bin/sh
# build the timer bank testbench with Verilator and run it
# exit status is nonzero unless the pass line shows up

verilator --binary --timing -f src.f --top-module tb_tmr_subsys -Mdir obj_dir &&
./obj_dir/Vtb_tmr_subsys | tee /dev/stderr | grep "Simulation passed" > /dev/null &&
echo "run.sh: done" ||
{
    echo "run.sh: build or simulation did not pass"
    exit 1
}
